/* Makefile */
SRCS := $(filter-out +%,$(shell cat verilog.f)) hazard_defs.svh

obj_dir/Vtb_hazard_unit: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_hazard_unit -f verilog.f

run: obj_dir/Vtb_hazard_unit
	./obj_dir/Vtb_hazard_unit

clean:
	rm -rf obj_dir

.PHONY: run clean

/* hazard_config.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hazard_defs.svh"

module hazard_config (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cfg_we,
    input  logic [1:0]              cfg_wdata, // [0] fwd enable, [1] clear count.
    input  logic                    stall,
    output logic                    fwd_en,
    output logic [`STALL_CNT_W-1:0] stall_count
);

    logic cnt_clr;
    logic cnt_max;

    assign cnt_clr = cfg_we && cfg_wdata[1];
    assign cnt_max = &stall_count; // saturated.

    // forwarding enable.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fwd_en <= `CFG_FWD_EN_RST;
        end else if (cfg_we) begin
            fwd_en <= cfg_wdata[0];
        end
    end

    // stall cycle counter.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stall_count <= '0;
        end else if (cnt_clr) begin
            stall_count <= '0; // clear beats increment.
        end else if (stall && !cnt_max) begin
            stall_count <= stall_count + 1'b1;
        end
    end

    // saturating, so max only leaves to zero through a clear.
    a_no_wrap : assert property (
        @(posedge clk) disable iff (!arst_n)
        (cnt_max && !cnt_clr) |=> (stall_count != '0)
    ) else $error("hazard_config: stall counter wrapped");

endmodule

`default_nettype wire

/* hazard_defs.svh */
`ifndef HAZARD_DEFS_SVH
`define HAZARD_DEFS_SVH

// datapath width of rv32i.
`define RV_XLEN 32

// register address width, x0..x31.
`define RV_REG_W 5

// stall counter width, saturates at all ones.
`define STALL_CNT_W 16

// forwarding on out of reset.
`define CFG_FWD_EN_RST 1'b1

`endif

/* hazard_detection.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hazard_defs.svh"

module hazard_detection (
    input  rv_hazard_pkg::inst_dec_t id_dec,
    input  rv_hazard_pkg::inst_dec_t ex_dec,
    input  rv_hazard_pkg::inst_dec_t mem_dec,
    input  logic                     fwd_en,
    output rv_hazard_pkg::fwd_sel_e  fwd_rs1,
    output rv_hazard_pkg::fwd_sel_e  fwd_rs2,
    output logic                     stall
);

    import rv_hazard_pkg::*;

    logic rs1_ex;  // rs1 produced by ex.
    logic rs1_mem; // rs1 produced by mem.
    logic rs2_ex;
    logic rs2_mem;
    logic load_use;
    logic raw_any;

    // source depends on an older stage.
    function automatic logic src_hit(
        input logic                 id_valid,
        input logic                 reads,
        input logic [`RV_REG_W-1:0] rs,
        input inst_dec_t            stg
    );
        return id_valid && reads && (rs != '0)
            && stg.valid && stg.writes_rd && (rs == stg.rd);
    endfunction

    assign rs1_ex  = src_hit(id_dec.valid, id_dec.reads_rs1, id_dec.rs1, ex_dec);
    assign rs1_mem = src_hit(id_dec.valid, id_dec.reads_rs1, id_dec.rs1, mem_dec);
    assign rs2_ex  = src_hit(id_dec.valid, id_dec.reads_rs2, id_dec.rs2, ex_dec);
    assign rs2_mem = src_hit(id_dec.valid, id_dec.reads_rs2, id_dec.rs2, mem_dec);

    // load data not ready until mem.
    assign load_use = ex_dec.is_load && (rs1_ex || rs2_ex);
    assign raw_any  = rs1_ex || rs1_mem || rs2_ex || rs2_mem;

    always_comb begin
        fwd_rs1 = FWD_NONE;
        fwd_rs2 = FWD_NONE;
        stall   = 1'b0;
        if (fwd_en) begin
            // each source on its own, ex is newer so it wins.
            if (rs1_ex) begin
                fwd_rs1 = FWD_EX;
            end else if (rs1_mem) begin
                fwd_rs1 = FWD_MEM;
            end
            if (rs2_ex) begin
                fwd_rs2 = FWD_EX;
            end else if (rs2_mem) begin
                fwd_rs2 = FWD_MEM;
            end
            if (load_use) begin
                stall   = 1'b1;
                fwd_rs1 = FWD_NONE; // operands re-picked next cycle.
                fwd_rs2 = FWD_NONE;
            end
        end else begin
            stall = raw_any; // wait until the writer leaves mem.
        end

        // ex select only with a live inst in ex.
        a_fwd_ex_valid : assert (!(fwd_rs1 == FWD_EX || fwd_rs2 == FWD_EX) || ex_dec.valid)
            else $error("hazard_detection: FWD_EX with empty ex stage");
        // a bubble in id never stalls.
        a_stall_id_valid : assert (!stall || id_dec.valid)
            else $error("hazard_detection: stall without valid id inst");
    end

endmodule

`default_nettype wire

/* hazard_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hazard_defs.svh"

module hazard_unit_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [31:0]             id_inst,     // raw word in id.
    input  logic                    id_valid,
    input  logic [`RV_XLEN-1:0]     rs1_data,
    input  logic [`RV_XLEN-1:0]     rs2_data,
    input  logic [`RV_XLEN-1:0]     ex_result,   // produced in ex this cycle.
    input  logic [`RV_XLEN-1:0]     mem_result,  // produced in mem this cycle.
    input  logic                    cfg_we,
    input  logic [1:0]              cfg_wdata,
    output logic                    stall,
    output rv_hazard_pkg::fwd_sel_e fwd_rs1,
    output rv_hazard_pkg::fwd_sel_e fwd_rs2,
    output logic [`RV_XLEN-1:0]     ex_op_a,
    output logic [`RV_XLEN-1:0]     ex_op_b,
    output logic                    fwd_en,
    output logic [`STALL_CNT_W-1:0] stall_count
);

    import rv_hazard_pkg::*;

    inst_dec_t id_dec;  // decoded id inst.
    inst_dec_t ex_dec;  // tracked ex inst.
    inst_dec_t mem_dec; // tracked mem inst.

    inst_decoder u_dec (
        .inst_valid (id_valid),
        .inst       (id_inst),
        .dec        (id_dec)
    );

    pipeline_tracker u_track (
        .clk     (clk),
        .arst_n  (arst_n),
        .id_dec  (id_dec),
        .stall   (stall),
        .ex_dec  (ex_dec),
        .mem_dec (mem_dec)
    );

    hazard_detection u_detect (
        .id_dec  (id_dec),
        .ex_dec  (ex_dec),
        .mem_dec (mem_dec),
        .fwd_en  (fwd_en),
        .fwd_rs1 (fwd_rs1),
        .fwd_rs2 (fwd_rs2),
        .stall   (stall)
    );

    hazard_config u_cfg (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg_we      (cfg_we),
        .cfg_wdata   (cfg_wdata),
        .stall       (stall),
        .fwd_en      (fwd_en),
        .stall_count (stall_count)
    );

    operand_forward u_fwd (
        .clk        (clk),
        .arst_n     (arst_n),
        .fwd_rs1    (fwd_rs1),
        .fwd_rs2    (fwd_rs2),
        .stall      (stall),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ex_result  (ex_result),
        .mem_result (mem_result),
        .ex_op_a    (ex_op_a),
        .ex_op_b    (ex_op_b)
    );

endmodule

`default_nettype wire

/* inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic                    inst_valid,
    input  logic [31:0]             inst,
    output rv_hazard_pkg::inst_dec_t dec
);

    import rv_hazard_pkg::*;

    opcode_e opc;
    logic    rd_nz; // rd other than x0.

    assign opc   = opcode_e'(inst[6:0]);
    assign rd_nz = (inst[11:7] != '0);

    always_comb begin
        dec        = '0;
        dec.valid  = inst_valid;
        dec.opcode = opc;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        case (opc)
            LUI, AUIPC, JAL: begin
                dec.writes_rd = rd_nz; // no sources.
            end
            JALR, OP_IMM: begin
                dec.reads_rs1 = 1'b1;
                dec.writes_rd = rd_nz;
            end
            LOAD: begin
                dec.reads_rs1 = 1'b1; // base address.
                dec.writes_rd = rd_nz;
                dec.is_load   = 1'b1;
            end
            STORE, BRANCH: begin
                dec.reads_rs1 = 1'b1;
                dec.reads_rs2 = 1'b1; // no destination.
            end
            OP: begin
                dec.reads_rs1 = 1'b1;
                dec.reads_rs2 = 1'b1;
                dec.writes_rd = rd_nz;
            end
            default: begin
                // unknown opcode, treated as using no registers.
                dec.writes_rd = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* operand_forward.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hazard_defs.svh"

module operand_forward (
    input  logic                    clk,
    input  logic                    arst_n,
    input  rv_hazard_pkg::fwd_sel_e fwd_rs1,
    input  rv_hazard_pkg::fwd_sel_e fwd_rs2,
    input  logic                    stall,
    input  logic [`RV_XLEN-1:0]     rs1_data,   // regfile read port a.
    input  logic [`RV_XLEN-1:0]     rs2_data,   // regfile read port b.
    input  logic [`RV_XLEN-1:0]     ex_result,
    input  logic [`RV_XLEN-1:0]     mem_result,
    output logic [`RV_XLEN-1:0]     ex_op_a,
    output logic [`RV_XLEN-1:0]     ex_op_b
);

    import rv_hazard_pkg::*;

    operand_pair_t opnd_d;
    operand_pair_t opnd_q;
    logic          opnd_load;

    // three way operand mux.
    function automatic logic [`RV_XLEN-1:0] pick(
        input fwd_sel_e            sel,
        input logic [`RV_XLEN-1:0] rf,
        input logic [`RV_XLEN-1:0] ex,
        input logic [`RV_XLEN-1:0] mem
    );
        case (sel)
            FWD_EX:  return ex;
            FWD_MEM: return mem;
            default: return rf;
        endcase
    endfunction

    assign opnd_d.op_a = pick(fwd_rs1, rs1_data, ex_result, mem_result);
    assign opnd_d.op_b = pick(fwd_rs2, rs2_data, ex_result, mem_result);
    assign opnd_load   = !stall; // hold on stall.

    pipe_stage #(
        .payload_t (operand_pair_t)
    ) u_opnd_stage (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (opnd_load),
        .clear  (1'b0),
        .d      (opnd_d),
        .q      (opnd_q)
    );

    assign ex_op_a = opnd_q.op_a;
    assign ex_op_b = opnd_q.op_b;

endmodule

`default_nettype wire

/* pipe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     load,  // capture d.
    input  logic     clear, // drop to a bubble.
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (clear) begin
            q <= '0; // bubble, valid bit goes low.
        end else if (load) begin
            q <= d;
        end
        // otherwise hold.
    end

    // a stage is either advanced or flushed, never both.
    a_load_clear_excl : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(load && clear)
    ) else $error("pipe_stage: load and clear high together");

endmodule

`default_nettype wire

/* pipeline_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_tracker (
    input  logic                     clk,
    input  logic                     arst_n,
    input  rv_hazard_pkg::inst_dec_t id_dec,
    input  logic                     stall,
    output rv_hazard_pkg::inst_dec_t ex_dec,
    output rv_hazard_pkg::inst_dec_t mem_dec
);

    import rv_hazard_pkg::*;

    logic ex_load;

    assign ex_load = !stall; // id advances only without a stall.

    // ex stage, bubble injected on stall.
    pipe_stage #(
        .payload_t (inst_dec_t)
    ) u_ex_stage (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (ex_load),
        .clear  (stall),
        .d      (id_dec),
        .q      (ex_dec)
    );

    // mem stage, always drains ex.
    pipe_stage #(
        .payload_t (inst_dec_t)
    ) u_mem_stage (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (1'b1),
        .clear  (1'b0),
        .d      (ex_dec),
        .q      (mem_dec)
    );

    // stall from detection must leave a bubble behind in ex.
    a_stall_bubble : assert property (
        @(posedge clk) disable iff (!arst_n)
        stall |=> !ex_dec.valid
    ) else $error("pipeline_tracker: no bubble in ex after stall");

endmodule

`default_nettype wire

/* rv_hazard_pkg.sv */
`default_nettype none

`include "hazard_defs.svh"

package rv_hazard_pkg;

    // rv32i major opcodes, bits [6:0] of the instruction word.
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_e;

    // decoded instruction as carried down the pipe.
    // all zeros is a bubble.
    typedef struct packed {
        logic                 valid;
        opcode_e              opcode;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_REG_W-1:0] rs1;
        logic [`RV_REG_W-1:0] rs2;
        logic                 writes_rd; // never set for rd of x0.
        logic                 reads_rs1;
        logic                 reads_rs2;
        logic                 is_load;
    } inst_dec_t;

    // operand source select.
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0, // register file.
        FWD_EX   = 2'd1, // result of the inst in ex.
        FWD_MEM  = 2'd2  // result of the inst in mem.
    } fwd_sel_e;

    // operand pair registered into ex.
    typedef struct packed {
        logic [`RV_XLEN-1:0] op_a;
        logic [`RV_XLEN-1:0] op_b;
    } operand_pair_t;

endpackage

`default_nettype wire

/* tb_hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hazard_defs.svh"

module tb_hazard_unit;

    import rv_hazard_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int RST_CYCLES  = 16;
    localparam int RUN_CYCLES  = 3000; // random instruction cycles.
    localparam int WATCHDOG_NS = (RST_CYCLES + RUN_CYCLES + 400) * CLK_PERIOD;

    logic                    clk;
    logic                    arst_n;
    logic [31:0]             id_inst;
    logic                    id_valid;
    logic [`RV_XLEN-1:0]     rs1_data;
    logic [`RV_XLEN-1:0]     rs2_data;
    logic [`RV_XLEN-1:0]     ex_result;
    logic [`RV_XLEN-1:0]     mem_result;
    logic                    cfg_we;
    logic [1:0]              cfg_wdata;
    logic                    stall;
    fwd_sel_e                fwd_rs1;
    fwd_sel_e                fwd_rs2;
    logic [`RV_XLEN-1:0]     ex_op_a;
    logic [`RV_XLEN-1:0]     ex_op_b;
    logic                    fwd_en;
    logic [`STALL_CNT_W-1:0] stall_count;

    integer     seed;
    logic [6:0] opc_tab [16]; // weighted opcode pool.
    logic       stall_seen;   // stall as seen by upstream.

    // shadow pipe.
    inst_dec_t               sh_id;
    inst_dec_t               sh_ex;
    inst_dec_t               sh_mem;
    logic [6:0]              id_opc;
    logic                    id_known;
    logic                    d1_ex;
    logic                    d1_mem;
    logic                    d2_ex;
    logic                    d2_mem;
    logic                    exp_stall;
    fwd_sel_e                exp_sel1;
    fwd_sel_e                exp_sel2;
    logic [`RV_XLEN-1:0]     exp_op_a;
    logic [`RV_XLEN-1:0]     exp_op_b;
    logic [`RV_XLEN-1:0]     exp_opa_q; // operands as they should sit in ex.
    logic [`RV_XLEN-1:0]     exp_opb_q;
    logic                    exp_fwd_en;
    logic [`STALL_CNT_W-1:0] exp_count;

    hazard_unit_top dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .id_inst     (id_inst),
        .id_valid    (id_valid),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex_result   (ex_result),
        .mem_result  (mem_result),
        .cfg_we      (cfg_we),
        .cfg_wdata   (cfg_wdata),
        .stall       (stall),
        .fwd_rs1     (fwd_rs1),
        .fwd_rs2     (fwd_rs2),
        .ex_op_a     (ex_op_a),
        .ex_op_b     (ex_op_b),
        .fwd_en      (fwd_en),
        .stall_count (stall_count)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) stall_seen <= stall; // steady between edges.

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic show_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
        stop_on_error($sformatf("Fail at %0t: %s expected %0h got %0h",
                                $time, name, exp_v, act_v));
    endtask

    // older stage produces register rs.
    function automatic logic writes_reg(input inst_dec_t stg, input logic [4:0] rs);
        return stg.valid && stg.writes_rd && (rs != 5'd0) && (stg.rd == rs);
    endfunction

    // id decode straight from the rv32i usage rules.
    always_comb begin
        id_opc          = id_inst[6:0];
        id_known        = id_opc inside {LUI, AUIPC, JAL, JALR, LOAD, STORE, BRANCH,
                                         OP_IMM, OP};
        sh_id           = '0;
        sh_id.valid     = id_valid;
        sh_id.opcode    = opcode_e'(id_opc);
        sh_id.rd        = id_inst[11:7];
        sh_id.rs1       = id_inst[19:15];
        sh_id.rs2       = id_inst[24:20];
        sh_id.reads_rs1 = id_known && !(id_opc inside {LUI, AUIPC, JAL});
        sh_id.reads_rs2 = id_opc inside {OP, STORE, BRANCH};
        sh_id.writes_rd = id_known && !(id_opc inside {STORE, BRANCH})
                          && (id_inst[11:7] != 5'd0);
        sh_id.is_load   = (id_opc == LOAD);
    end

    // expected selects and stall.
    always_comb begin
        d1_ex     = sh_id.valid && sh_id.reads_rs1 && writes_reg(sh_ex, sh_id.rs1);
        d1_mem    = sh_id.valid && sh_id.reads_rs1 && writes_reg(sh_mem, sh_id.rs1);
        d2_ex     = sh_id.valid && sh_id.reads_rs2 && writes_reg(sh_ex, sh_id.rs2);
        d2_mem    = sh_id.valid && sh_id.reads_rs2 && writes_reg(sh_mem, sh_id.rs2);
        exp_stall = 1'b0;
        exp_sel1  = FWD_NONE;
        exp_sel2  = FWD_NONE;
        if (!exp_fwd_en) begin
            exp_stall = d1_ex || d1_mem || d2_ex || d2_mem; // every raw waits.
        end else if (sh_ex.is_load && (d1_ex || d2_ex)) begin
            exp_stall = 1'b1; // load-use.
        end else begin
            exp_sel1 = d1_ex ? FWD_EX : (d1_mem ? FWD_MEM : FWD_NONE); // newest wins.
            exp_sel2 = d2_ex ? FWD_EX : (d2_mem ? FWD_MEM : FWD_NONE);
        end
        exp_op_a = (exp_sel1 == FWD_EX) ? ex_result
                 : (exp_sel1 == FWD_MEM) ? mem_result : rs1_data;
        exp_op_b = (exp_sel2 == FWD_EX) ? ex_result
                 : (exp_sel2 == FWD_MEM) ? mem_result : rs2_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sh_ex      <= '0;
            sh_mem     <= '0;
            exp_opa_q  <= '0;
            exp_opb_q  <= '0;
            exp_fwd_en <= `CFG_FWD_EN_RST;
            exp_count  <= '0;
        end else begin
            sh_mem <= sh_ex;
            if (exp_stall) begin
                sh_ex <= '0; // bubble.
            end else begin
                sh_ex     <= sh_id;
                exp_opa_q <= exp_op_a;
                exp_opb_q <= exp_op_b;
            end
            if (cfg_we) exp_fwd_en <= cfg_wdata[0];
            if (cfg_we && cfg_wdata[1]) begin
                exp_count <= '0; // clear first.
            end else if (exp_stall && (exp_count != '1)) begin
                exp_count <= exp_count + 1'b1;
            end
        end
    end

    a_stall : assert property (@(posedge clk) disable iff (!arst_n) stall == exp_stall)
        else show_mismatch("stall", 64'($sampled(exp_stall)), 64'($sampled(stall)));
    a_sel1 : assert property (@(posedge clk) disable iff (!arst_n) fwd_rs1 == exp_sel1)
        else show_mismatch("fwd_rs1", 64'($sampled(exp_sel1)), 64'($sampled(fwd_rs1)));
    a_sel2 : assert property (@(posedge clk) disable iff (!arst_n) fwd_rs2 == exp_sel2)
        else show_mismatch("fwd_rs2", 64'($sampled(exp_sel2)), 64'($sampled(fwd_rs2)));
    a_op_a : assert property (@(posedge clk) disable iff (!arst_n) ex_op_a == exp_opa_q)
        else show_mismatch("ex_op_a", 64'($sampled(exp_opa_q)), 64'($sampled(ex_op_a)));
    a_op_b : assert property (@(posedge clk) disable iff (!arst_n) ex_op_b == exp_opb_q)
        else show_mismatch("ex_op_b", 64'($sampled(exp_opb_q)), 64'($sampled(ex_op_b)));
    a_fwd_en : assert property (@(posedge clk) disable iff (!arst_n) fwd_en == exp_fwd_en)
        else show_mismatch("fwd_en", 64'($sampled(exp_fwd_en)), 64'($sampled(fwd_en)));
    a_count : assert property (@(posedge clk) disable iff (!arst_n)
        stall_count == exp_count)
        else show_mismatch("stall_count", 64'($sampled(exp_count)),
                           64'($sampled(stall_count)));

    // load-use lasts one cycle, then the load is taken from mem.
    a_load_use : assert property (@(posedge clk) disable iff (!arst_n)
        (stall && fwd_en && !cfg_we) |=>
        (!stall && (fwd_rs1 == FWD_MEM || fwd_rs2 == FWD_MEM)))
        else stop_on_error("load-use stall did not end in a forward from MEM");
    a_no_src : assert property (@(posedge clk) disable iff (!arst_n)
        (id_valid && (id_inst[6:0] inside {LUI, AUIPC, JAL})) |->
        (!stall && fwd_rs1 == FWD_NONE && fwd_rs2 == FWD_NONE))
        else stop_on_error("instruction without sources caused a stall or a forward");
    a_x0_rs1 : assert property (@(posedge clk) disable iff (!arst_n)
        (id_inst[19:15] == 5'd0) |-> (fwd_rs1 == FWD_NONE))
        else stop_on_error("rs1 of x0 selected a forward");
    a_x0_rs2 : assert property (@(posedge clk) disable iff (!arst_n)
        (id_inst[24:20] == 5'd0) |-> (fwd_rs2 == FWD_NONE))
        else stop_on_error("rs2 of x0 selected a forward");
    a_fwd_off : assert property (@(posedge clk) disable iff (!arst_n)
        !fwd_en |-> (fwd_rs1 == FWD_NONE && fwd_rs2 == FWD_NONE))
        else stop_on_error("forward selected while forwarding is disabled");
    a_clear : assert property (@(posedge clk) disable iff (!arst_n)
        (cfg_we && cfg_wdata[1]) |=> (stall_count == '0))
        else stop_on_error("stall counter not zero after a clear write");

    // random word, registers x0..x3 only.
    task automatic pick_inst(output logic [31:0] word);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r    = $random(seed);
        rd   = {3'b000, r[5:4]};
        rs1  = {3'b000, r[7:6]};
        rs2  = {3'b000, r[9:8]};
        word = {7'b0000000, rs2, rs1, 3'b000, rd, opc_tab[r[3:0]]};
    endtask

    task automatic drive_cycle(input logic we, input logic [1:0] wdata);
        logic [31:0] word;
        logic [31:0] r;
        @(posedge clk);
        pick_inst(word);
        r = $random(seed);
        cfg_we     <= we;
        cfg_wdata  <= wdata;
        rs1_data   <= $random(seed);
        rs2_data   <= $random(seed);
        ex_result  <= $random(seed);
        mem_result <= $random(seed);
        if (!stall_seen) begin
            id_inst  <= word; // held otherwise.
            id_valid <= (r[2:0] != 3'b000);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("watchdog expired before the test sequence finished");
    end

    initial begin
        seed    = 38;
        opc_tab = '{LUI, AUIPC, JAL, JALR, LOAD, LOAD, LOAD, STORE,
                    BRANCH, OP_IMM, OP_IMM, OP, OP, OP, STORE, 7'b1111111};
        arst_n     <= 1'b0;
        id_inst    <= '0;
        id_valid   <= 1'b0;
        rs1_data   <= '0;
        rs2_data   <= '0;
        ex_result  <= '0;
        mem_result <= '0;
        cfg_we     <= 1'b0;
        cfg_wdata  <= 2'b00;
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < RUN_CYCLES; i++) begin
            case (i)
                500:     drive_cycle(1'b1, 2'b11); // count clear, forwarding on.
                1000:    drive_cycle(1'b1, 2'b10); // forwarding off with clear.
                1600:    drive_cycle(1'b1, 2'b00); // still off, count kept.
                2000:    drive_cycle(1'b1, 2'b01); // back on.
                2600:    drive_cycle(1'b1, 2'b11);
                default: drive_cycle(1'b0, 2'b00);
            endcase
        end
        repeat (3) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
rv_hazard_pkg.sv
pipe_stage.sv
inst_decoder.sv
hazard_detection.sv
hazard_config.sv
pipeline_tracker.sv
operand_forward.sv
hazard_unit_top.sv
tb_hazard_unit.sv
